// File: rtl/byteRam.sv
`timescale 1ns/1ps

module byteRam #(
    parameter int RamAddrWidth = 12
) (
    input logic   clk,
    ramPortIf.ram ram
);

    memPkg::byteT            mem [2**RamAddrWidth];
    logic [RamAddrWidth-1:0] index;

    // upper address bits ignored, so accesses wrap
    assign index = ram.addr[RamAddrWidth-1:0];

    always_ff @(posedge clk) begin
        if (ram.we) begin
            mem[index] <= ram.wdata;
        end
        // read returns the old byte on a write to the same address
        ram.rdata <= mem[index];
    end

endmodule

// File: rtl/byteSequencer.sv
`timescale 1ns/1ps

module byteSequencer (
    input  logic        clk,
    input  logic        rst,
    input  logic        hold,
    memReqIf.sequencer  req,
    ramPortIf.sequencer ram
);

    reqPkg::seqStateE state;
    reqPkg::beatT     beat;
    reqPkg::beatT     beatCount;
    reqPkg::beatT     prevBeat;
    reqPkg::beatT     addrBeat;
    memPkg::wordT     loadWord;
    logic             active;
    logic             step;
    logic             lastBeat;

    always_comb begin
        case (req.size)
            reqPkg::sizeByte: beatCount = reqPkg::beatT'(1);
            reqPkg::sizeHalf: beatCount = reqPkg::beatT'(2);
            default:          beatCount = reqPkg::beatT'(4);
        endcase
    end

    // beat 0 goes out in the first cycle valid is seen
    assign active = (state == reqPkg::seqRun)
                  || (state == reqPkg::seqIdle && req.valid);
    assign step   = active && !hold;

    // stores end on the last write, loads one beat later
    assign lastBeat = req.write ? (beat == beatCount - reqPkg::beatT'(1))
                                : (beat == beatCount);

    assign prevBeat = beat - reqPkg::beatT'(1);

    // while held, re-read the previous byte so rdata still carries it
    // once the hold is released
    assign addrBeat = hold ? prevBeat : beat;

    assign ram.addr  = req.addr + memPkg::addrT'(addrBeat);
    assign ram.we    = step && req.write;
    assign ram.wdata = req.wdata[{beat[1:0], 3'b000} +: 8];

    assign req.done  = step && lastBeat;

    // last byte comes straight from the RAM, upper bytes stay zero
    assign req.rdata = loadWord
                     | (memPkg::wordT'(ram.rdata) << {prevBeat[1:0], 3'b000});

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= reqPkg::seqIdle;
            beat  <= '0;
        end else begin
            case (state)
                reqPkg::seqIdle,
                reqPkg::seqRun: begin
                    if (step) begin
                        if (lastBeat) begin
                            state <= reqPkg::seqDone;
                            beat  <= '0;
                        end else begin
                            state <= reqPkg::seqRun;
                            beat  <= beat + reqPkg::beatT'(1);
                        end
                    end
                end
                // arbiter drops valid in this cycle
                default: begin
                    state <= reqPkg::seqIdle;
                end
            endcase
        end
    end

    // byte k-1 arrives during beat k
    always_ff @(posedge clk) begin
        if (state != reqPkg::seqRun) begin
            loadWord <= '0;
        end else if (step && !req.write && !lastBeat) begin
            loadWord[{prevBeat[1:0], 3'b000} +: 8] <= ram.rdata;
        end
    end

endmodule

// File: rtl/memPkg.sv
package memPkg;

    // one RAM location
    typedef logic [7:0] byteT;

    // full data or instruction word
    typedef logic [31:0] wordT;

    // byte address as seen by both requesters
    typedef logic [31:0] addrT;

endpackage

// File: rtl/memReqIf.sv
`timescale 1ns/1ps

interface memReqIf;

    logic               valid;
    logic               write;
    reqPkg::accessSizeE size;
    memPkg::addrT       addr;
    memPkg::wordT       wdata;

    // load result, valid together with done
    memPkg::wordT       rdata;
    logic               done;

    modport arbiter (
        output valid,
        output write,
        output size,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport sequencer (
        input  valid,
        input  write,
        input  size,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

// File: rtl/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem #(
    parameter int RamAddrWidth = 12
) (
    input  logic         clk,
    input  logic         rst,

    // freezes the transfer in progress
    input  logic         hold,

    // instruction fetch port
    input  logic         fCyc,
    input  logic         fStb,
    input  memPkg::addrT fAdr,
    output memPkg::wordT fDatR,
    output logic         fAck,

    // data port
    input  logic         dCyc,
    input  logic         dStb,
    input  logic         dWe,
    input  logic [3:0]   dSel,
    input  memPkg::addrT dAdr,
    input  memPkg::wordT dDatW,
    output memPkg::wordT dDatR,
    output logic         dAck
);

    memReqIf  reqBus ();
    ramPortIf ramBus ();

    portArbiter arbiter_i (
        .clk   (clk),
        .rst   (rst),
        .fCyc  (fCyc),
        .fStb  (fStb),
        .fAdr  (fAdr),
        .fDatR (fDatR),
        .fAck  (fAck),
        .dCyc  (dCyc),
        .dStb  (dStb),
        .dWe   (dWe),
        .dSel  (dSel),
        .dAdr  (dAdr),
        .dDatW (dDatW),
        .dDatR (dDatR),
        .dAck  (dAck),
        .req   (reqBus.arbiter)
    );

    byteSequencer sequencer_i (
        .clk  (clk),
        .rst  (rst),
        .hold (hold),
        .req  (reqBus.sequencer),
        .ram  (ramBus.sequencer)
    );

    byteRam #(
        .RamAddrWidth (RamAddrWidth)
    ) ram_i (
        .clk (clk),
        .ram (ramBus.ram)
    );

endmodule

// File: rtl/portArbiter.sv
`timescale 1ns/1ps

module portArbiter (
    input  logic         clk,
    input  logic         rst,

    // instruction fetch port
    input  logic         fCyc,
    input  logic         fStb,
    input  memPkg::addrT fAdr,
    output memPkg::wordT fDatR,
    output logic         fAck,

    // data port
    input  logic         dCyc,
    input  logic         dStb,
    input  logic         dWe,
    input  logic [3:0]   dSel,
    input  memPkg::addrT dAdr,
    input  memPkg::wordT dDatW,
    output memPkg::wordT dDatR,
    output logic         dAck,

    memReqIf.arbiter     req
);

    reqPkg::ownerE      owner;
    logic               dataReq;
    logic               fetchReq;

    logic               reqWrite;
    reqPkg::accessSizeE reqSize;
    memPkg::addrT       reqAddr;
    memPkg::wordT       reqWdata;

    // anything other than a byte or half lane mask counts as a word
    function automatic reqPkg::accessSizeE selToSize(input logic [3:0] sel);
        case (sel)
            4'b0001: return reqPkg::sizeByte;
            4'b0011: return reqPkg::sizeHalf;
            default: return reqPkg::sizeWord;
        endcase
    endfunction

    assign dataReq  = dCyc && dStb;
    assign fetchReq = fCyc && fStb;

    // data port wins a tie
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= reqPkg::ownerNone;
        end else if (owner == reqPkg::ownerNone) begin
            if (dataReq) begin
                owner <= reqPkg::ownerData;
            end else if (fetchReq) begin
                owner <= reqPkg::ownerFetch;
            end
        end else if (req.done) begin
            owner <= reqPkg::ownerNone;
        end
    end

    // request fields latched with the grant
    always_ff @(posedge clk) begin
        if (owner == reqPkg::ownerNone) begin
            if (dataReq) begin
                reqWrite <= dWe;
                reqSize  <= selToSize(dSel);
                reqAddr  <= dAdr;
                reqWdata <= dDatW;
            end else begin
                // fetch is always a word read
                reqWrite <= 1'b0;
                reqSize  <= reqPkg::sizeWord;
                reqAddr  <= fAdr;
                reqWdata <= '0;
            end
        end
    end

    assign req.valid = (owner != reqPkg::ownerNone);
    assign req.write = reqWrite;
    assign req.size  = reqSize;
    assign req.addr  = reqAddr;
    assign req.wdata = reqWdata;

    // done goes back to whichever port owns the access
    assign fAck  = req.done && (owner == reqPkg::ownerFetch);
    assign dAck  = req.done && (owner == reqPkg::ownerData);
    assign fDatR = (owner == reqPkg::ownerFetch) ? req.rdata : '0;
    assign dDatR = (owner == reqPkg::ownerData) ? req.rdata : '0;

endmodule

// File: rtl/ramPortIf.sv
`timescale 1ns/1ps

interface ramPortIf;

    logic         we;
    memPkg::addrT addr;
    memPkg::byteT wdata;

    // byte at the address of the previous cycle
    memPkg::byteT rdata;

    modport sequencer (
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport ram (
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// File: rtl/reqPkg.sv
package reqPkg;

    // access width, decoded from dSel on the data port
    typedef enum logic [1:0] {
        sizeByte = 2'd0,
        sizeHalf = 2'd1,
        sizeWord = 2'd2
    } accessSizeE;

    // port that holds the current grant
    typedef enum logic [1:0] {
        ownerNone  = 2'd0,
        ownerData  = 2'd1,
        ownerFetch = 2'd2
    } ownerE;

    typedef enum logic [1:0] {
        seqIdle = 2'd0,
        seqRun  = 2'd1,
        seqDone = 2'd2
    } seqStateE;

    // counts beats zero through four
    typedef logic [2:0] beatT;

endpackage

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, exit status is the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f src.f --top-module memSubsystemTb -o memSubsystemSim \
    && ./obj_dir/memSubsystemSim \
    || { echo "memSubsystemTb: build or run returned an error" >&2; exit 1; }

// File: src.f
rtl/memPkg.sv
rtl/reqPkg.sv
rtl/memReqIf.sv
rtl/ramPortIf.sv
rtl/portArbiter.sv
rtl/byteSequencer.sv
rtl/byteRam.sv
rtl/memSubsystem.sv
tb/memSubsystemTb.sv

// File: tb/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;

    localparam int RamAddrWidth = 12;
    localparam int RamBytes = 2 ** RamAddrWidth;

    typedef enum {opFetch, opLoad, opStore, opFetchAndLoad} opE;

    typedef struct {
        opE          op;
        logic [31:0] addr;
        logic [3:0]  sel;
        logic [31:0] data;
        bit          randData;
        int          holdDensity;
        bit          hasExp;
        logic [31:0] expData;
    } entryT;

    logic        clk;
    logic        rst;
    logic        hold;
    logic        fCyc;
    logic        fStb;
    logic [31:0] fAdr;
    logic [31:0] fDatR;
    logic        fAck;
    logic        dCyc;
    logic        dStb;
    logic        dWe;
    logic [3:0]  dSel;
    logic [31:0] dAdr;
    logic [31:0] dDatW;
    logic [31:0] dDatR;
    logic        dAck;

    entryT       stimulus[$];
    logic [7:0]  model [RamBytes];
    bit          written [RamBytes];
    logic [31:0] rngState = 32'h31ac21ec;
    int          cycleCount = 0;
    int          timeoutLimit = 0;

    memSubsystem #(
        .RamAddrWidth (RamAddrWidth)
    ) dut_i (
        .clk   (clk),
        .rst   (rst),
        .hold  (hold),
        .fCyc  (fCyc),
        .fStb  (fStb),
        .fAdr  (fAdr),
        .fDatR (fDatR),
        .fAck  (fAck),
        .dCyc  (dCyc),
        .dStb  (dStb),
        .dWe   (dWe),
        .dSel  (dSel),
        .dAdr  (dAdr),
        .dDatW (dDatW),
        .dDatR (dDatR),
        .dAck  (dAck)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // bytes covered by a lane mask where any other mask means a word
    function automatic int sizeOf(input logic [3:0] sel);
        case (sel)
            4'b0001: return 1;
            4'b0011: return 2;
            default: return 4;
        endcase
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount > timeoutLimit) begin
            failRun($sformatf("timeout: no end of the run after %0d cycles", cycleCount));
        end
    end

    task automatic addEntry(input opE op, input logic [31:0] addr, input logic [3:0] sel,
                            input logic [31:0] data, input bit randData, input int holdDensity,
                            input bit hasExp, input logic [31:0] expData);
        entryT e;
        e.op          = op;
        e.addr        = addr;
        e.sel         = sel;
        e.data        = data;
        e.randData    = randData;
        e.holdDensity = holdDensity;
        e.hasExp      = hasExp;
        e.expData     = expData;
        stimulus.push_back(e);
    endtask

    task automatic buildTable();
        // all sizes at one address and a byte store between kept neighbours
        addEntry(opStore, 32'h100, 4'b1111, 32'ha1b2c3d4, 0, 0, 0, 32'h0);
        addEntry(opLoad,  32'h100, 4'b1111, 32'h0,        0, 0, 1, 32'ha1b2c3d4);
        addEntry(opLoad,  32'h100, 4'b0011, 32'h0,        0, 0, 1, 32'h0000c3d4);
        addEntry(opLoad,  32'h100, 4'b0001, 32'h0,        0, 0, 1, 32'h000000d4);
        addEntry(opStore, 32'h100, 4'b0011, 32'hffff5e6f, 0, 0, 0, 32'h0);
        addEntry(opStore, 32'h102, 4'b0001, 32'hffffff77, 0, 0, 0, 32'h0);
        addEntry(opLoad,  32'h101, 4'b0001, 32'h0,        0, 0, 1, 32'h0000005e);
        addEntry(opLoad,  32'h102, 4'b0011, 32'h0,        0, 0, 1, 32'h0000a177);
        addEntry(opLoad,  32'h100, 4'b1111, 32'h0,        0, 0, 1, 32'ha1775e6f);
        // unaligned half and then fetches across it
        addEntry(opStore, 32'h200, 4'b1111, 32'h11223344, 0, 0, 0, 32'h0);
        addEntry(opStore, 32'h204, 4'b1111, 32'h55667788, 0, 0, 0, 32'h0);
        addEntry(opStore, 32'h203, 4'b0011, 32'h0000beef, 0, 0, 0, 32'h0);
        addEntry(opFetch, 32'h201, 4'b1111, 32'h0,        0, 0, 1, 32'hbeef2233);
        addEntry(opLoad,  32'h203, 4'b0011, 32'h0,        0, 0, 1, 32'h0000beef);
        addEntry(opFetch, 32'h202, 4'b1111, 32'h0,        0, 0, 1, 32'h77beef22);
        // both ports at once
        addEntry(opFetchAndLoad, 32'h200, 4'b1111, 32'h0, 0, 0, 1, 32'hef223344);
        addEntry(opFetchAndLoad, 32'h100, 4'b0001, 32'h0, 0, 0, 0, 32'h0);
        // random hold cycles
        addEntry(opStore, 32'h300, 4'b1111, 32'h0, 1, 3, 0, 32'h0);
        addEntry(opStore, 32'h304, 4'b1111, 32'h0, 1, 3, 0, 32'h0);
        addEntry(opLoad,  32'h300, 4'b1111, 32'h0, 0, 3, 0, 32'h0);
        addEntry(opLoad,  32'h301, 4'b0011, 32'h0, 0, 4, 0, 32'h0);
        addEntry(opFetch, 32'h302, 4'b1111, 32'h0, 0, 3, 0, 32'h0);
        addEntry(opStore, 32'h305, 4'b0001, 32'h0, 1, 4, 0, 32'h0);
        addEntry(opFetchAndLoad, 32'h303, 4'b0001, 32'h0, 0, 3, 0, 32'h0);
        addEntry(opStore, 32'h307, 4'b0011, 32'h0, 1, 2, 0, 32'h0);
        addEntry(opLoad,  32'h305, 4'b1111, 32'h0, 0, 4, 0, 32'h0);
        // back to back with random data
        addEntry(opStore, 32'h400, 4'b1111, 32'h0, 1, 0, 0, 32'h0);
        addEntry(opStore, 32'h404, 4'b0011, 32'h0, 1, 0, 0, 32'h0);
        addEntry(opLoad,  32'h401, 4'b1111, 32'h0, 0, 0, 0, 32'h0);
        addEntry(opStore, 32'h400, 4'b0001, 32'h0, 1, 0, 0, 32'h0);
        addEntry(opLoad,  32'h400, 4'b0001, 32'h0, 0, 0, 0, 32'h0);
        addEntry(opStore, 32'h402, 4'b1111, 32'h0, 1, 0, 0, 32'h0);
        addEntry(opLoad,  32'h403, 4'b0011, 32'h0, 0, 0, 0, 32'h0);
        addEntry(opFetch, 32'h400, 4'b1111, 32'h0, 0, 0, 0, 32'h0);
        addEntry(opLoad,  32'h402, 4'b1111, 32'h0, 0, 0, 0, 32'h0);
    endtask

    // hold is high with a chance of density in eight
    task automatic drawHold(input int density);
        rngState = xorshift(rngState);
        hold = (density > 0) && (int'(rngState[10:8]) < density);
    endtask

    task automatic storeModel(input logic [31:0] addr, input int n, input logic [31:0] data);
        logic [31:0] a;
        for (int i = 0; i < n; i++) begin
            a = addr + 32'(i);
            model[a[RamAddrWidth-1:0]] = data[8*i +: 8];
            written[a[RamAddrWidth-1:0]] = 1'b1;
        end
    endtask

    // little endian with upper bytes left at zero
    task automatic readModel(input logic [31:0] addr, input int n, output logic [31:0] word);
        logic [31:0] a;
        word = '0;
        for (int i = 0; i < n; i++) begin
            a = addr + 32'(i);
            if (!written[a[RamAddrWidth-1:0]]) begin
                failRun($sformatf("table reads byte 0x%h before any store to it", a));
            end
            word[8*i +: 8] = model[a[RamAddrWidth-1:0]];
        end
    endtask

    // called 1 ns after a rising edge and samples 3 ns after it
    task automatic idleCycles(input int n);
        repeat (n) begin
            #2;
            checkEq("fAck", 32'(fAck), 32'h0);
            checkEq("dAck", 32'(dAck), 32'h0);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runEntry(input entryT e);
        logic [31:0] wdata;
        logic [31:0] loadExp;
        logic [31:0] fetchExp;
        bit          dataPend;
        bit          fetchPend;
        bit          firstCycle;
        int          n;
        n = sizeOf(e.sel);
        dataPend = (e.op != opFetch);
        fetchPend = (e.op == opFetch) || (e.op == opFetchAndLoad);
        wdata = e.data;
        if (e.randData) begin
            rngState = xorshift(rngState);
            wdata = rngState;
        end
        if (e.op == opStore) begin
            storeModel(e.addr, n, wdata);
        end
        if (e.op == opLoad || e.op == opFetchAndLoad) begin
            readModel(e.addr, n, loadExp);
        end
        if (fetchPend) begin
            readModel(e.addr, 4, fetchExp);
        end

        dCyc = dataPend;
        dStb = dataPend;
        dWe = (e.op == opStore);
        dSel = e.sel;
        dAdr = e.addr;
        dDatW = wdata;
        fCyc = fetchPend;
        fStb = fetchPend;
        fAdr = e.addr;
        firstCycle = 1'b1;

        while (dataPend || fetchPend) begin
            drawHold(e.holdDensity);
            #2;
            if (hold && (fAck || dAck)) begin
                failRun("an ack came in a cycle with hold high");
            end
            if (fAck) begin
                if (!fetchPend || firstCycle) begin
                    failRun("fAck came without a pending fetch");
                end
                if (dataPend) begin
                    failRun("fAck came before dAck on simultaneous requests");
                end
                checkEq("fDatR", fDatR, fetchExp);
                if (e.hasExp) begin
                    checkEq("fDatR", fDatR, e.expData);
                end
                fetchPend = 1'b0;
            end
            if (dAck) begin
                if (!dataPend || firstCycle) begin
                    failRun("dAck came without a pending data request");
                end
                if (e.op != opStore) begin
                    checkEq("dDatR", dDatR, loadExp);
                    if (e.hasExp) begin
                        checkEq("dDatR", dDatR, e.expData);
                    end
                end
                dataPend = 1'b0;
            end
            @(posedge clk);
            #1;
            firstCycle = 1'b0;
            // a finished port drops its strobe right after the ack
            if (!dataPend) begin
                dCyc = 1'b0;
                dStb = 1'b0;
                dWe = 1'b0;
            end
            if (!fetchPend) begin
                fCyc = 1'b0;
                fStb = 1'b0;
            end
        end
        hold = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        hold = 1'b0;
        fCyc = 1'b0;
        fStb = 1'b0;
        fAdr = '0;
        dCyc = 1'b0;
        dStb = 1'b0;
        dWe = 1'b0;
        dSel = 4'b0000;
        dAdr = '0;
        dDatW = '0;
        buildTable();
        timeoutLimit = 16 + 20 * stimulus.size() + 200;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        idleCycles(4);

        for (int i = 0; i < stimulus.size(); i++) begin
            runEntry(stimulus[i]);
        end
        // no stray acks once the table is done
        idleCycles(4);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
